// ==== dpPkg.sv ====
`default_nettype none

package dpPkg;

    // width of every register and operand
    localparam int dataWidth = 8;

    // operations accepted on the opCode port
    typedef enum logic [4:0] {
        opAdc,
        opSbc,
        opAnd,
        opEor,
        opOra,
        opLsr,
        opRor,
        opLda,
        opLdx,
        opLdy,
        opTax,
        opTay,
        opTxa,
        opTya,
        opSec,
        opClc,
        opSed,
        opCld,
        opSei,
        opCli
    } opCodeT;

    // ALU function select
    typedef enum logic [2:0] {
        aluSum,
        aluAnd,
        aluEor,
        aluOra,
        aluShr,
        aluPassB
    } aluFuncT;

    // register write-back source
    typedef enum logic [1:0] {
        wbAlu,
        wbAcc,
        wbX,
        wbY
    } wbSelT;

    // bit positions of NV-BDIZC in the status byte
    localparam int flagN = 7;
    localparam int flagV = 6;
    localparam int flagB = 4;
    localparam int flagD = 3;
    localparam int flagI = 2;
    localparam int flagZ = 1;
    localparam int flagC = 0;

    // bit 5 reads as one and everything else is clear
    localparam logic [dataWidth-1:0] statusReset = 8'h20;

endpackage

`default_nettype wire

// ==== aluCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluCore import dpPkg::*; (
    input  wire logic [dataWidth-1:0] aIn,
    input  wire logic [dataWidth-1:0] bIn,
    input  wire aluFuncT              aluFunc,
    input  wire logic                 invertB,
    input  wire logic                 carryIn,
    output logic [dataWidth-1:0]      aluOut,
    output logic                      acr,
    output logic                      avr,
    output logic                      hc
);

    logic [dataWidth-1:0] bEff;
    logic [4:0]           loSum;
    logic [4:0]           hiSum;
    logic [dataWidth-1:0] sumOut;

    // subtract is add with the operand inverted
    assign bEff = invertB ? ~bIn : bIn;

    // two nibble steps so the half carry falls out
    assign loSum  = {1'b0, aIn[3:0]} + {1'b0, bEff[3:0]} + {4'b0000, carryIn};
    assign hiSum  = {1'b0, aIn[7:4]} + {1'b0, bEff[7:4]} + {4'b0000, loSum[4]};
    assign sumOut = {hiSum[3:0], loSum[3:0]};

    always_comb begin
        aluOut = bIn;
        acr    = 1'b0;
        avr    = 1'b0;
        hc     = 1'b0;
        case (aluFunc)
            aluSum: begin
                aluOut = sumOut;
                acr    = hiSum[4];
                hc     = loSum[4];
                // same sign in, different sign out
                avr    = (aIn[dataWidth-1] == bEff[dataWidth-1]) &&
                         (sumOut[dataWidth-1] != aIn[dataWidth-1]);
            end
            aluAnd: aluOut = aIn & bIn;
            aluEor: aluOut = aIn ^ bIn;
            aluOra: aluOut = aIn | bIn;
            aluShr: begin
                aluOut = {carryIn, aIn[dataWidth-1:1]};
                acr    = aIn[0];
            end
            // loads just forward the operand
            aluPassB: aluOut = bIn;
            default: aluOut = bIn;
        endcase
    end

endmodule

`default_nettype wire

// ==== decimalAdjust.sv ====
`timescale 1ns/10ps
`default_nettype none

module decimalAdjust import dpPkg::*; (
    input  wire logic [dataWidth-1:0] sumIn,
    input  wire logic                 acr,
    input  wire logic                 hc,
    input  wire logic                 daa,
    input  wire logic                 dsa,
    output logic [dataWidth-1:0]      adjOut,
    output logic                      carryOut
);

    always_comb begin
        adjOut   = sumIn;
        carryOut = acr;
        if (daa) begin
            // low digit overflowed past 9
            if (sumIn[3:0] > 4'd9 || hc) begin
                adjOut = adjOut + 8'h06;
            end
            // high digit out of range gives a BCD carry out
            if (acr || sumIn > 8'h99) begin
                adjOut   = adjOut + 8'h60;
                carryOut = 1'b1;
            end
        end else if (dsa) begin
            // a clear carry here means a borrow from that digit
            if (!hc) begin
                adjOut = adjOut - 8'h06;
            end
            if (!acr) begin
                adjOut = adjOut - 8'h60;
            end
        end
    end

endmodule

`default_nettype wire

// ==== opDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module opDecode import dpPkg::*; #(
    parameter bit decimalEnable = 1'b1
) (
    input  wire logic    opValid,
    input  wire opCodeT  opCode,
    input  wire logic    decMode,
    input  wire logic    carryFlag,
    output aluFuncT      aluFunc,
    output logic         invertB,
    output logic         carryIn,
    output logic         daa,
    output logic         dsa,
    output logic         loadAcc,
    output logic         loadX,
    output logic         loadY,
    output wbSelT        srcSel,
    output logic         flagsNz,
    output logic         flagsCv,
    output logic         setC,
    output logic         clrC,
    output logic         setD,
    output logic         clrD,
    output logic         setI,
    output logic         clrI
);

    logic decOn;

    // decimal arithmetic only when D is set and the build allows it
    assign decOn = decMode & decimalEnable;

    always_comb begin
        aluFunc = aluPassB;
        invertB = 1'b0;
        carryIn = 1'b0;
        daa     = 1'b0;
        dsa     = 1'b0;
        loadAcc = 1'b0;
        loadX   = 1'b0;
        loadY   = 1'b0;
        srcSel  = wbAlu;
        flagsNz = 1'b0;
        flagsCv = 1'b0;
        setC    = 1'b0;
        clrC    = 1'b0;
        setD    = 1'b0;
        clrD    = 1'b0;
        setI    = 1'b0;
        clrI    = 1'b0;
        if (opValid) begin
            case (opCode)
                opAdc, opSbc: begin
                    aluFunc = aluSum;
                    carryIn = carryFlag;
                    invertB = (opCode == opSbc);
                    daa     = decOn & (opCode == opAdc);
                    dsa     = decOn & (opCode == opSbc);
                    loadAcc = 1'b1;
                    flagsNz = 1'b1;
                    flagsCv = 1'b1;
                end
                opAnd, opEor, opOra: begin
                    aluFunc = (opCode == opAnd) ? aluAnd :
                              (opCode == opEor) ? aluEor : aluOra;
                    loadAcc = 1'b1;
                    flagsNz = 1'b1;
                end
                opLsr, opRor: begin
                    aluFunc = aluShr;
                    // LSR shifts in zero, ROR the old carry
                    carryIn = (opCode == opRor) & carryFlag;
                    loadAcc = 1'b1;
                    flagsNz = 1'b1;
                    // both C strobes together load C with the shifted-out bit
                    setC    = 1'b1;
                    clrC    = 1'b1;
                end
                opLda, opLdx, opLdy: begin
                    aluFunc = aluPassB;
                    loadAcc = (opCode == opLda);
                    loadX   = (opCode == opLdx);
                    loadY   = (opCode == opLdy);
                    flagsNz = 1'b1;
                end
                opTax, opTay: begin
                    srcSel  = wbAcc;
                    loadX   = (opCode == opTax);
                    loadY   = (opCode == opTay);
                    flagsNz = 1'b1;
                end
                opTxa, opTya: begin
                    srcSel  = (opCode == opTxa) ? wbX : wbY;
                    loadAcc = 1'b1;
                    flagsNz = 1'b1;
                end
                opSec: setC = 1'b1;
                opClc: clrC = 1'b1;
                opSed: setD = 1'b1;
                opCld: clrD = 1'b1;
                opSei: setI = 1'b1;
                opCli: clrI = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile import dpPkg::*; (
    input  wire logic                 rstAll,
    input  wire logic                 rstN,
    input  wire logic [dataWidth-1:0] resultIn,
    input  wire logic                 loadAcc,
    input  wire logic                 loadX,
    input  wire logic                 loadY,
    input  wire wbSelT                srcSel,
    output logic [dataWidth-1:0]      acc,
    output logic [dataWidth-1:0]      xReg,
    output logic [dataWidth-1:0]      yReg,
    output logic [dataWidth-1:0]      nzValue
);

    logic [dataWidth-1:0] writeVal;

    // ALU result for arithmetic and loads, another register for transfers
    always_comb begin
        case (srcSel)
            wbAlu:   writeVal = resultIn;
            wbAcc:   writeVal = acc;
            wbX:     writeVal = xReg;
            wbY:     writeVal = yReg;
            default: writeVal = resultIn;
        endcase
    end

    // flags see the value about to be written
    assign nzValue = writeVal;

    always_ff @(posedge rstAll or negedge rstN) begin
        if (!rstN) begin
            acc <= '0;
        end else if (loadAcc) begin
            acc <= writeVal;
        end
    end

    always_ff @(posedge rstAll or negedge rstN) begin
        if (!rstN) begin
            xReg <= '0;
        end else if (loadX) begin
            xReg <= writeVal;
        end
    end

    always_ff @(posedge rstAll or negedge rstN) begin
        if (!rstN) begin
            yReg <= '0;
        end else if (loadY) begin
            yReg <= writeVal;
        end
    end

endmodule

`default_nettype wire

// ==== statusFlags.sv ====
`timescale 1ns/10ps
`default_nettype none

module statusFlags import dpPkg::*; (
    input  wire logic                 rstAll,
    input  wire logic                 rstN,
    input  wire logic [dataWidth-1:0] nzValue,
    input  wire logic                 carryIn,
    input  wire logic                 avr,
    input  wire logic                 flagsNz,
    input  wire logic                 flagsCv,
    input  wire logic                 setC,
    input  wire logic                 clrC,
    input  wire logic                 setD,
    input  wire logic                 clrD,
    input  wire logic                 setI,
    input  wire logic                 clrI,
    output logic [dataWidth-1:0]      status
);

    logic nFlag;
    logic vFlag;
    logic dFlag;
    logic iFlag;
    logic zFlag;
    logic cFlag;

    always_ff @(posedge rstAll or negedge rstN) begin
        if (!rstN) begin
            nFlag <= statusReset[flagN];
            vFlag <= statusReset[flagV];
            dFlag <= statusReset[flagD];
            iFlag <= statusReset[flagI];
            zFlag <= statusReset[flagZ];
            cFlag <= statusReset[flagC];
        end else begin
            if (flagsNz) begin
                nFlag <= nzValue[dataWidth-1];
                zFlag <= (nzValue == '0);
            end
            // arithmetic updates C and V together
            if (flagsCv) begin
                cFlag <= carryIn;
                vFlag <= avr;
            end else if (setC && clrC) begin
                // a shift loads C alone
                cFlag <= carryIn;
            end else if (setC) begin
                cFlag <= 1'b1;
            end else if (clrC) begin
                cFlag <= 1'b0;
            end
            if (setD) begin
                dFlag <= 1'b1;
            end else if (clrD) begin
                dFlag <= 1'b0;
            end
            if (setI) begin
                iFlag <= 1'b1;
            end else if (clrI) begin
                iFlag <= 1'b0;
            end
        end
    end

    // bit 5 stays high and B stays low
    always_comb begin
        status        = statusReset;
        status[flagN] = nFlag;
        status[flagV] = vFlag;
        status[flagB] = 1'b0;
        status[flagD] = dFlag;
        status[flagI] = iFlag;
        status[flagZ] = zFlag;
        status[flagC] = cFlag;
    end

endmodule

`default_nettype wire

// ==== dataPath.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataPath import dpPkg::*; #(
    parameter bit decimalEnable = 1'b1
) (
    input  wire logic                 rstAll,
    input  wire logic                 rstN,
    input  wire logic                 opValid,
    input  wire opCodeT               opCode,
    input  wire logic [dataWidth-1:0] operand,
    output logic [dataWidth-1:0]      acc,
    output logic [dataWidth-1:0]      xReg,
    output logic [dataWidth-1:0]      yReg,
    output logic [dataWidth-1:0]      status
);

    aluFuncT              aluFunc;
    wbSelT                srcSel;
    logic                 invertB;
    logic                 carryIn;
    logic                 daa;
    logic                 dsa;
    logic                 loadAcc;
    logic                 loadX;
    logic                 loadY;
    logic                 flagsNz;
    logic                 flagsCv;
    logic                 setC;
    logic                 clrC;
    logic                 setD;
    logic                 clrD;
    logic                 setI;
    logic                 clrI;
    logic [dataWidth-1:0] aluOut;
    logic                 acr;
    logic                 avr;
    logic                 hc;
    logic [dataWidth-1:0] adjOut;
    logic                 carryOut;
    logic [dataWidth-1:0] nzValue;

    opDecode #(
        .decimalEnable(decimalEnable)
    ) u_opDecode (
        .opValid  (opValid),
        .opCode   (opCode),
        .decMode  (status[flagD]),
        .carryFlag(status[flagC]),
        .aluFunc  (aluFunc),
        .invertB  (invertB),
        .carryIn  (carryIn),
        .daa      (daa),
        .dsa      (dsa),
        .loadAcc  (loadAcc),
        .loadX    (loadX),
        .loadY    (loadY),
        .srcSel   (srcSel),
        .flagsNz  (flagsNz),
        .flagsCv  (flagsCv),
        .setC     (setC),
        .clrC     (clrC),
        .setD     (setD),
        .clrD     (clrD),
        .setI     (setI),
        .clrI     (clrI)
    );

    aluCore u_aluCore (
        .aIn    (acc),
        .bIn    (operand),
        .aluFunc(aluFunc),
        .invertB(invertB),
        .carryIn(carryIn),
        .aluOut (aluOut),
        .acr    (acr),
        .avr    (avr),
        .hc     (hc)
    );

    decimalAdjust u_decimalAdjust (
        .sumIn   (aluOut),
        .acr     (acr),
        .hc      (hc),
        .daa     (daa),
        .dsa     (dsa),
        .adjOut  (adjOut),
        .carryOut(carryOut)
    );

    regFile u_regFile (
        .rstAll  (rstAll),
        .rstN    (rstN),
        .resultIn(adjOut),
        .loadAcc (loadAcc),
        .loadX   (loadX),
        .loadY   (loadY),
        .srcSel  (srcSel),
        .acc     (acc),
        .xReg    (xReg),
        .yReg    (yReg),
        .nzValue (nzValue)
    );

    statusFlags u_statusFlags (
        .rstAll (rstAll),
        .rstN   (rstN),
        .nzValue(nzValue),
        .carryIn(carryOut),
        .avr    (avr),
        .flagsNz(flagsNz),
        .flagsCv(flagsCv),
        .setC   (setC),
        .clrC   (clrC),
        .setD   (setD),
        .clrD   (clrD),
        .setI   (setI),
        .clrI   (clrI),
        .status (status)
    );

endmodule

`default_nettype wire

// ==== tbDataPath.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbDataPath import dpPkg::*; ();

    localparam int phaseBinary  = 0;
    localparam int phaseLogic   = 1;
    localparam int phaseMoves   = 2;
    localparam int phaseFlags   = 3;
    localparam int phaseAll     = 4;
    localparam int watchdogTime = 200000;

    logic                 rstAll;
    logic                 rstN;
    logic                 opValid;
    opCodeT               opCode;
    logic [dataWidth-1:0] operand;
    logic [dataWidth-1:0] acc;
    logic [dataWidth-1:0] xReg;
    logic [dataWidth-1:0] yReg;
    logic [dataWidth-1:0] status;

    // reference copies of the architectural state
    logic [7:0]  mAcc;
    logic [7:0]  mX;
    logic [7:0]  mY;
    logic [7:0]  mStatus;
    logic [31:0] rngState;
    int          errors;
    int          checks;

    dataPath #(
        .decimalEnable(1'b1)
    ) u_dataPath (
        .rstAll (rstAll),
        .rstN   (rstN),
        .opValid(opValid),
        .opCode (opCode),
        .operand(operand),
        .acc    (acc),
        .xReg   (xReg),
        .yReg   (yReg),
        .status (status)
    );

    always #50 rstAll = ~rstAll;

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // two random decimal digits
    function automatic logic [7:0] bcdByte(input logic [31:0] r);
        logic [3:0] hi;
        logic [3:0] lo;
        hi = r[7:4] % 4'd10;
        lo = r[3:0] % 4'd10;
        return {hi, lo};
    endfunction

    // registers cleared and status at 8'h20
    function automatic bit atResetState();
        return acc === 8'h00 && xReg === 8'h00 && yReg === 8'h00 && status === 8'h20;
    endfunction

    function automatic opCodeT pickOp(input int phase, input logic [31:0] r);
        case (phase)
            phaseBinary: begin
                case (r % 5)
                    0: return opAdc;
                    1: return opSbc;
                    2: return opSec;
                    3: return opClc;
                    default: return opLda;
                endcase
            end
            phaseLogic: begin
                case (r % 6)
                    0: return opAnd;
                    1: return opEor;
                    2: return opOra;
                    3: return opLsr;
                    4: return opRor;
                    default: return opAdc;
                endcase
            end
            phaseMoves: begin
                case (r % 7)
                    0: return opLda;
                    1: return opLdx;
                    2: return opLdy;
                    3: return opTax;
                    4: return opTay;
                    5: return opTxa;
                    default: return opTya;
                endcase
            end
            phaseFlags: begin
                case (r % 4)
                    0: return opSec;
                    1: return opClc;
                    2: return opSei;
                    default: return opCli;
                endcase
            end
            default: return opCodeT'(r[20:16] % 5'd20);
        endcase
    endfunction

    task automatic setNz(input logic [7:0] v);
        mStatus[flagN] = v[7];
        mStatus[flagZ] = (v == 8'h00);
    endtask

    // one operation on the reference state
    task automatic applyModel(input opCodeT op, input logic [7:0] val);
        logic [8:0] sum;
        logic [7:0] b;
        logic [7:0] res;
        logic       half;
        logic       cin;
        cin = mStatus[flagC];
        case (op)
            opAdc, opSbc: begin
                b    = (op == opSbc) ? ~val : val;
                sum  = {1'b0, mAcc} + {1'b0, b} + {8'h00, cin};
                half = ({1'b0, mAcc[3:0]} + {1'b0, b[3:0]} + {4'h0, cin}) > 5'd15;
                res  = sum[7:0];
                // V from the binary sum in both modes
                mStatus[flagV] = (mAcc[7] == b[7]) && (res[7] != mAcc[7]);
                mStatus[flagC] = sum[8];
                if (mStatus[flagD] && op == opAdc) begin
                    if (res[3:0] > 4'd9 || half) res = res + 8'h06;
                    if (sum[8] || sum > 9'h099) begin
                        res = res + 8'h60;
                        mStatus[flagC] = 1'b1;
                    end
                end else if (mStatus[flagD]) begin
                    if (!half) res = res - 8'h06;
                    if (!sum[8]) res = res - 8'h60;
                end
                mAcc = res;
                setNz(mAcc);
            end
            opAnd: begin
                mAcc = mAcc & val;
                setNz(mAcc);
            end
            opEor: begin
                mAcc = mAcc ^ val;
                setNz(mAcc);
            end
            opOra: begin
                mAcc = mAcc | val;
                setNz(mAcc);
            end
            opLsr, opRor: begin
                mStatus[flagC] = mAcc[0];
                mAcc = {(op == opRor) ? cin : 1'b0, mAcc[7:1]};
                setNz(mAcc);
            end
            opLda: begin
                mAcc = val;
                setNz(mAcc);
            end
            opLdx: begin
                mX = val;
                setNz(mX);
            end
            opLdy: begin
                mY = val;
                setNz(mY);
            end
            opTax: begin
                mX = mAcc;
                setNz(mX);
            end
            opTay: begin
                mY = mAcc;
                setNz(mY);
            end
            opTxa: begin
                mAcc = mX;
                setNz(mAcc);
            end
            opTya: begin
                mAcc = mY;
                setNz(mAcc);
            end
            opSec: mStatus[flagC] = 1'b1;
            opClc: mStatus[flagC] = 1'b0;
            opSed: mStatus[flagD] = 1'b1;
            opCld: mStatus[flagD] = 1'b0;
            opSei: mStatus[flagI] = 1'b1;
            opCli: mStatus[flagI] = 1'b0;
            default: ;
        endcase
    endtask

    task automatic checkOutputs();
        checks++;
        if (acc !== mAcc) begin
            $display("[ERROR] t=%0t acc got %02h expected %02h", $time, acc, mAcc);
            errors++;
        end
        if (xReg !== mX) begin
            $display("[ERROR] t=%0t xReg got %02h expected %02h", $time, xReg, mX);
            errors++;
        end
        if (yReg !== mY) begin
            $display("[ERROR] t=%0t yReg got %02h expected %02h", $time, yReg, mY);
            errors++;
        end
        if (status !== mStatus) begin
            $display("[ERROR] t=%0t status got %02h expected %02h", $time, status, mStatus);
            errors++;
        end
    endtask

    // drive one cycle, then check what the previous cycle left behind
    task automatic step(input logic valid, input opCodeT op, input logic [7:0] val);
        @(posedge rstAll);
        opValid <= valid;
        opCode  <= op;
        operand <= val;
        @(negedge rstAll);
        checkOutputs();
        if (valid) applyModel(op, val);
    endtask

    task automatic runPhase(input int phase, input int count, input bit allowIdle,
                            input bit bcd);
        logic [31:0] r;
        logic [31:0] r2;
        logic [7:0]  val;
        for (int i = 0; i < count; i++) begin
            r   = nextRand();
            r2  = nextRand();
            val = bcd ? bcdByte(r2) : r2[15:8];
            // roughly one idle cycle in five, with junk on the op lines
            if (allowIdle && (r % 5 == 0)) begin
                step(1'b0, opCodeT'(r[20:16] % 5'd20), val);
            end else begin
                step(1'b1, pickOp(phase, r2), val);
            end
        end
    endtask

    initial begin
        rstAll   = 1'b0;
        rstN     = 1'b0;
        opValid  = 1'b0;
        opCode   = opAdc;
        operand  = 8'h00;
        rngState = 32'h847a_3874;
        mAcc     = 8'h00;
        mX       = 8'h00;
        mY       = 8'h00;
        mStatus  = 8'h20;
        errors   = 0;
        checks   = 0;

        repeat (8) @(posedge rstAll);
        // the registers must show their reset values before release
        for (int n = 0; n < 16 && !atResetState(); n++) @(posedge rstAll);
        if (!atResetState()) begin
            $display("DUT registers never reached their reset values during reset");
            errors++;
        end
        rstN <= 1'b1;

        // reset values, then idle cycles that must not change anything
        repeat (4) step(1'b0, opLda, 8'hff);

        step(1'b1, opCld, 8'h00);
        runPhase(phaseBinary, 80, 1'b1, 1'b0);

        // decimal mode with BCD accumulator and operands
        step(1'b1, opSed, 8'h00);
        step(1'b1, opLda, 8'h45);
        runPhase(phaseBinary, 80, 1'b1, 1'b1);
        step(1'b1, opCld, 8'h00);
        runPhase(phaseBinary, 20, 1'b1, 1'b0);

        runPhase(phaseLogic, 60, 1'b1, 1'b0);
        runPhase(phaseMoves, 60, 1'b0, 1'b0);
        runPhase(phaseFlags, 30, 1'b1, 1'b0);
        runPhase(phaseAll, 300, 1'b1, 1'b0);

        // flush the last operation
        step(1'b0, opAdc, 8'h00);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog against a stalled run
    initial begin
        for (int t = 0; t < watchdogTime; t++) #100;
        $display("timeout, the run did not complete in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
dpPkg.sv
aluCore.sv
decimalAdjust.sv
opDecode.sv
regFile.sv
statusFlags.sv
dataPath.sv
tbDataPath.sv

// ==== Bender.yml ====
package:
  name: dataPath

sources:
  - dpPkg.sv
  - aluCore.sv
  - decimalAdjust.sv
  - opDecode.sv
  - regFile.sv
  - statusFlags.sv
  - dataPath.sv
  - target: simulation
    files:
      - tbDataPath.sv
